// File: rtl/fill_counter.sv
`timescale 1ns/100ps

`include "rename_consts.svh"

module fill_counter
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic fill_step,
	output pr_tag_t fill_tag0,
	output pr_tag_t fill_tag1,
	output logic fill_done
);

	pr_tag_t fill_base;

	assign fill_tag0 = fill_base;
	assign fill_tag1 = fill_base + pr_tag_t'(1);
	assign fill_done = (fill_base == pr_tag_t'(`PR_COUNT - 2));

	// First free tag sits just past the identity mappings
	always_ff @(posedge clock)
	begin
		if (reset)
			fill_base <= pr_tag_t'(`AR_COUNT);
		else if (fill_step && !fill_done)
			fill_base <= fill_base + pr_tag_t'(2);
	end

endmodule

// File: rtl/free_list.sv
`timescale 1ns/100ps

`include "rename_consts.svh"

module free_list
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic fill_push,
	input pr_tag_t fill_tag0,
	input pr_tag_t fill_tag1,
	input issue_count_t pop_num,
	input issue_count_t retire_num,
	input pr_tag_t retire_told0,
	input pr_tag_t retire_told1,
	output pr_tag_t head_tag0,
	output pr_tag_t head_tag1,
	output free_count_t free_count
);

	localparam logic [`FREE_PTR_WIDTH-1:0] PTR_ONE = 1;

	pr_tag_t entries [`FREE_DEPTH];

	logic [`FREE_PTR_WIDTH-1:0] head_ptr;
	logic [`FREE_PTR_WIDTH-1:0] tail_ptr;
	logic [`FREE_PTR_WIDTH-1:0] head_step;
	logic [`FREE_PTR_WIDTH-1:0] tail_step;
	free_count_t count;

	issue_count_t push_num;
	pr_tag_t push_tag0;
	pr_tag_t push_tag1;

	// Fill pair has priority, retirement is idle during fill
	assign push_num = fill_push ? 2'd2 : retire_num;
	assign push_tag0 = fill_push ? fill_tag0 : retire_told0;
	assign push_tag1 = fill_push ? fill_tag1 : retire_told1;

	assign head_step = {{(`FREE_PTR_WIDTH-2){1'b0}}, pop_num};
	assign tail_step = {{(`FREE_PTR_WIDTH-2){1'b0}}, push_num};

	assign head_tag0 = entries[head_ptr];
	assign head_tag1 = entries[head_ptr + PTR_ONE];
	assign free_count = count;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end
		else
		begin
			head_ptr <= head_ptr + head_step;
			tail_ptr <= tail_ptr + tail_step;
			count <= count + free_count_t'(push_num) - free_count_t'(pop_num);
		end
	end

	// Storage only
	always_ff @(posedge clock)
	begin
		if (push_num != 2'd0)
			entries[tail_ptr] <= push_tag0;
		if (push_num == 2'd2)
			entries[tail_ptr + PTR_ONE] <= push_tag1;
	end

endmodule

// File: rtl/map_table.sv
`timescale 1ns/100ps

`include "rename_consts.svh"

module map_table
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input issue_count_t dispatch_grant,
	input logic dest_a_valid,
	input logic dest_b_valid,
	input ar_tag_t dest_a,
	input ar_tag_t dest_b,
	input ar_tag_t src_a1,
	input ar_tag_t src_a2,
	input ar_tag_t src_b1,
	input ar_tag_t src_b2,
	input pr_tag_t head_tag0,
	input pr_tag_t head_tag1,
	input logic [`CDB_WIDTH-1:0] cdb_broadcast,
	input pr_tag_t cdb_pr_tag0,
	input pr_tag_t cdb_pr_tag1,
	input pr_tag_t cdb_pr_tag2,
	input pr_tag_t cdb_pr_tag3,
	input ar_tag_t cdb_ar_tag0,
	input ar_tag_t cdb_ar_tag1,
	input ar_tag_t cdb_ar_tag2,
	input ar_tag_t cdb_ar_tag3,
	output pr_tag_t pr_dest_a,
	output pr_tag_t pr_dest_b,
	output pr_tag_t told_a,
	output pr_tag_t told_b,
	output pr_tag_t pr_a1,
	output pr_tag_t pr_a2,
	output pr_tag_t pr_b1,
	output pr_tag_t pr_b2,
	output logic pr_a1_ready,
	output logic pr_a2_ready,
	output logic pr_b1_ready,
	output logic pr_b2_ready
);

	pr_tag_t map [`AR_COUNT];
	logic [`AR_COUNT-1:0] ready_bits;
	logic [`AR_COUNT-1:0] ready_next;

	pr_tag_t cdb_pr [`CDB_WIDTH];
	ar_tag_t cdb_ar [`CDB_WIDTH];

	logic write_a;
	logic write_b;
	logic b1_hits_a;
	logic b2_hits_a;
	logic told_b_hits_a;

	assign cdb_pr[0] = cdb_pr_tag0;
	assign cdb_pr[1] = cdb_pr_tag1;
	assign cdb_pr[2] = cdb_pr_tag2;
	assign cdb_pr[3] = cdb_pr_tag3;
	assign cdb_ar[0] = cdb_ar_tag0;
	assign cdb_ar[1] = cdb_ar_tag1;
	assign cdb_ar[2] = cdb_ar_tag2;
	assign cdb_ar[3] = cdb_ar_tag3;

	assign write_a = (dispatch_grant != 2'd0) && dest_a_valid;
	assign write_b = (dispatch_grant == 2'd2) && dest_b_valid;

	// Slot b skips over the tag slot a consumes
	assign pr_dest_a = head_tag0;
	assign pr_dest_b = dest_a_valid ? head_tag1 : head_tag0;

	// In-group dependences on slot a
	assign b1_hits_a = write_a && (src_b1 == dest_a);
	assign b2_hits_a = write_a && (src_b2 == dest_a);
	assign told_b_hits_a = write_a && (dest_b == dest_a);

	assign told_a = map[dest_a];
	assign told_b = told_b_hits_a ? pr_dest_a : map[dest_b];

	assign pr_a1 = map[src_a1];
	assign pr_a2 = map[src_a2];
	assign pr_a1_ready = ready_bits[src_a1];
	assign pr_a2_ready = ready_bits[src_a2];

	assign pr_b1 = b1_hits_a ? pr_dest_a : map[src_b1];
	assign pr_b2 = b2_hits_a ? pr_dest_a : map[src_b2];
	assign pr_b1_ready = b1_hits_a ? 1'b0 : ready_bits[src_b1];
	assign pr_b2_ready = b2_hits_a ? 1'b0 : ready_bits[src_b2];

	always_comb
	begin
		ready_next = ready_bits;
		// Stale broadcasts are ignored
		for (int i = 0; i < `CDB_WIDTH; i++)
		begin
			if (cdb_broadcast[i] && (map[cdb_ar[i]] == cdb_pr[i]))
				ready_next[cdb_ar[i]] = 1'b1;
		end
		// New mappings start not ready
		if (write_a)
			ready_next[dest_a] = 1'b0;
		if (write_b)
			ready_next[dest_b] = 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `AR_COUNT; i++)
				map[i] <= pr_tag_t'(i);
			ready_bits <= '1;
		end
		else
		begin
			ready_bits <= ready_next;
			if (write_a)
				map[dest_a] <= pr_dest_a;
			// Later write wins on a shared destination
			if (write_b)
				map[dest_b] <= pr_dest_b;
		end
	end

endmodule

// File: rtl/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural register file
`define AR_COUNT 32
`define AR_WIDTH 5

// Physical register file, top tag bit stays zero with 64 registers
`define PR_COUNT 64
`define PR_WIDTH 7

// Broadcast lanes on the CDB
`define CDB_WIDTH 4

// Free list sizing
`define FREE_DEPTH 32
`define FREE_PTR_WIDTH 5

`endif

// File: rtl/rename_ctrl.sv
`timescale 1ns/100ps

`include "rename_consts.svh"

module rename_ctrl
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input issue_count_t dispatch_num,
	input logic dest_a_valid,
	input logic dest_b_valid,
	input free_count_t free_count,
	input logic fill_done,
	output logic fill_step,
	output logic fill_push,
	output issue_count_t pop_num,
	output issue_count_t dispatch_grant,
	output logic rename_ready
);

	rename_state_t state;
	rename_state_t state_next;

	logic take_a;
	logic take_b;
	issue_count_t tags_needed;
	logic tags_available;

	// Destinations inside the offered group
	assign take_a = (dispatch_num != 2'd0) && dest_a_valid;
	assign take_b = (dispatch_num == 2'd2) && dest_b_valid;
	assign tags_needed = issue_count_t'(take_a) + issue_count_t'(take_b);
	assign tags_available = (free_count >= free_count_t'(tags_needed));

	assign fill_step = (state == RENAME_FILL);
	assign fill_push = (state == RENAME_FILL);
	assign rename_ready = (state == RENAME_RUN);

	// Whole group or nothing
	assign dispatch_grant = (rename_ready && tags_available) ? dispatch_num : 2'd0;
	assign pop_num = (dispatch_grant != 2'd0) ? tags_needed : 2'd0;

	always_comb
	begin
		state_next = state;
		case (state)
			RENAME_FILL:
			begin
				if (fill_done)
					state_next = RENAME_RUN;
			end
			RENAME_RUN:
			begin
				state_next = RENAME_RUN;
			end
			default:
			begin
				state_next = RENAME_FILL;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= RENAME_FILL;
		else
			state <= state_next;
	end

endmodule

// File: rtl/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

	typedef logic [`AR_WIDTH-1:0] ar_tag_t;
	typedef logic [`PR_WIDTH-1:0] pr_tag_t;

	// Zero to two instructions or tags
	typedef logic [1:0] issue_count_t;

	// Occupancy needs one bit over the pointer to reach full
	typedef logic [`FREE_PTR_WIDTH:0] free_count_t;

	typedef enum logic
	{
		RENAME_FILL,
		RENAME_RUN
	} rename_state_t;

endpackage

// File: rtl/rename_top.sv
`timescale 1ns/100ps

`include "rename_consts.svh"

module rename_top
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input issue_count_t dispatch_num,
	input logic dest_a_valid,
	input logic dest_b_valid,
	input ar_tag_t dest_a,
	input ar_tag_t dest_b,
	input ar_tag_t src_a1,
	input ar_tag_t src_a2,
	input ar_tag_t src_b1,
	input ar_tag_t src_b2,
	input logic [`CDB_WIDTH-1:0] cdb_broadcast,
	input pr_tag_t cdb_pr_tag0,
	input pr_tag_t cdb_pr_tag1,
	input pr_tag_t cdb_pr_tag2,
	input pr_tag_t cdb_pr_tag3,
	input ar_tag_t cdb_ar_tag0,
	input ar_tag_t cdb_ar_tag1,
	input ar_tag_t cdb_ar_tag2,
	input ar_tag_t cdb_ar_tag3,
	input issue_count_t retire_num,
	input pr_tag_t retire_told0,
	input pr_tag_t retire_told1,
	output logic rename_ready,
	output issue_count_t dispatch_grant,
	output pr_tag_t pr_dest_a,
	output pr_tag_t pr_dest_b,
	output pr_tag_t told_a,
	output pr_tag_t told_b,
	output pr_tag_t pr_a1,
	output pr_tag_t pr_a2,
	output pr_tag_t pr_b1,
	output pr_tag_t pr_b2,
	output logic pr_a1_ready,
	output logic pr_a2_ready,
	output logic pr_b1_ready,
	output logic pr_b2_ready
);

	free_count_t free_count;
	issue_count_t pop_num;
	logic fill_push;
	logic fill_step;
	logic fill_done;
	pr_tag_t fill_tag0;
	pr_tag_t fill_tag1;
	pr_tag_t head_tag0;
	pr_tag_t head_tag1;

	rename_ctrl ctrl (
		.clock(clock),
		.reset(reset),
		.dispatch_num(dispatch_num),
		.dest_a_valid(dest_a_valid),
		.dest_b_valid(dest_b_valid),
		.free_count(free_count),
		.fill_done(fill_done),
		.fill_step(fill_step),
		.fill_push(fill_push),
		.pop_num(pop_num),
		.dispatch_grant(dispatch_grant),
		.rename_ready(rename_ready)
	);

	fill_counter filler (
		.clock(clock),
		.reset(reset),
		.fill_step(fill_step),
		.fill_tag0(fill_tag0),
		.fill_tag1(fill_tag1),
		.fill_done(fill_done)
	);

	free_list fl (
		.clock(clock),
		.reset(reset),
		.fill_push(fill_push),
		.fill_tag0(fill_tag0),
		.fill_tag1(fill_tag1),
		.pop_num(pop_num),
		.retire_num(retire_num),
		.retire_told0(retire_told0),
		.retire_told1(retire_told1),
		.head_tag0(head_tag0),
		.head_tag1(head_tag1),
		.free_count(free_count)
	);

	map_table mt (
		.clock(clock),
		.reset(reset),
		.dispatch_grant(dispatch_grant),
		.dest_a_valid(dest_a_valid),
		.dest_b_valid(dest_b_valid),
		.dest_a(dest_a),
		.dest_b(dest_b),
		.src_a1(src_a1),
		.src_a2(src_a2),
		.src_b1(src_b1),
		.src_b2(src_b2),
		.head_tag0(head_tag0),
		.head_tag1(head_tag1),
		.cdb_broadcast(cdb_broadcast),
		.cdb_pr_tag0(cdb_pr_tag0),
		.cdb_pr_tag1(cdb_pr_tag1),
		.cdb_pr_tag2(cdb_pr_tag2),
		.cdb_pr_tag3(cdb_pr_tag3),
		.cdb_ar_tag0(cdb_ar_tag0),
		.cdb_ar_tag1(cdb_ar_tag1),
		.cdb_ar_tag2(cdb_ar_tag2),
		.cdb_ar_tag3(cdb_ar_tag3),
		.pr_dest_a(pr_dest_a),
		.pr_dest_b(pr_dest_b),
		.told_a(told_a),
		.told_b(told_b),
		.pr_a1(pr_a1),
		.pr_a2(pr_a2),
		.pr_b1(pr_b1),
		.pr_b2(pr_b2),
		.pr_a1_ready(pr_a1_ready),
		.pr_a2_ready(pr_a2_ready),
		.pr_b1_ready(pr_b1_ready),
		.pr_b2_ready(pr_b2_ready)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the rename stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module rename_tb -o rename_sim &&
./obj_dir/rename_sim | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: sim/rename_tb.sv
`timescale 1ns/100ps

`include "rename_consts.svh"

module rename_tb
	import rename_pkg::*;
();

	localparam pr_tag_t CURRENT_TAG = '1;
	localparam logic [1:0] ANY_GRANT = 2'd3;
	localparam int RANDOM_ROWS = 200;
	localparam int READY_TIMEOUT = 100;

	// One dispatch group, four CDB lanes and a retire group per row
	typedef struct packed
	{
		issue_count_t num;
		logic va;
		ar_tag_t da;
		logic vb;
		ar_tag_t db;
		ar_tag_t a1;
		ar_tag_t a2;
		ar_tag_t b1;
		ar_tag_t b2;
		logic [`CDB_WIDTH-1:0] cdb_v;
		logic [`CDB_WIDTH-1:0][`AR_WIDTH-1:0] cdb_ar;
		logic [`CDB_WIDTH-1:0][`PR_WIDTH-1:0] cdb_pr;
		issue_count_t ret;
		logic [1:0] exp_grant;
	} row_t;

	logic clock;
	logic reset;
	issue_count_t dispatch_num;
	logic dest_a_valid;
	logic dest_b_valid;
	ar_tag_t dest_a;
	ar_tag_t dest_b;
	ar_tag_t src_a1, src_a2, src_b1, src_b2;
	logic [`CDB_WIDTH-1:0] cdb_broadcast;
	pr_tag_t cdb_pr_tag0, cdb_pr_tag1, cdb_pr_tag2, cdb_pr_tag3;
	ar_tag_t cdb_ar_tag0, cdb_ar_tag1, cdb_ar_tag2, cdb_ar_tag3;
	issue_count_t retire_num;
	pr_tag_t retire_told0, retire_told1;
	logic rename_ready;
	issue_count_t dispatch_grant;
	pr_tag_t pr_dest_a, pr_dest_b, told_a, told_b;
	pr_tag_t pr_a1, pr_a2, pr_b1, pr_b2;
	logic pr_a1_ready, pr_a2_ready, pr_b1_ready, pr_b2_ready;

	// Reference model state
	pr_tag_t model_map [`AR_COUNT];
	logic [`AR_COUNT-1:0] model_ready;
	pr_tag_t free_q [$];
	pr_tag_t told_q [$];

	row_t rows [$];
	logic [15:0] lfsr;
	int errors;
	int rows_bad;

	rename_top dut (.*);

	always #4 clock = ~clock;

	function automatic int rand_bits(input int width);
		int value;
		int b;
		value = 0;
		for (b = 0; b < width; b++)
		begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return value;
	endfunction

	// Lanes marked CURRENT_TAG broadcast the register's present mapping
	function automatic pr_tag_t lane_tag(input row_t r, input int lane);
		if (r.cdb_pr[lane] == CURRENT_TAG)
			return model_map[r.cdb_ar[lane]];
		return r.cdb_pr[lane];
	endfunction

	task automatic check_tag(input string what, input pr_tag_t got, input pr_tag_t want);
		if (got !== want)
		begin
			$display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		if (got !== want)
		begin
			$display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_source(input string name, input pr_tag_t got_tag, input logic got_ready,
		input ar_tag_t src, input logic from_a, input pr_tag_t tag_a);
		check_tag(name, got_tag, from_a ? tag_a : model_map[src]);
		check_bit({name, " ready"}, got_ready, !from_a && model_ready[src]);
	endtask

	task automatic add_row(input int num, input int va, input int da, input int vb, input int db,
		input int a1, input int a2, input int b1, input int b2,
		input int cdb_v, input int cdb_ar, input int cdb_pr, input int ret, input int grant);
		row_t r;
		r = '0;
		r.num = issue_count_t'(num);
		r.va = (va != 0);
		r.da = ar_tag_t'(da);
		r.vb = (vb != 0);
		r.db = ar_tag_t'(db);
		r.a1 = ar_tag_t'(a1);
		r.a2 = ar_tag_t'(a2);
		r.b1 = ar_tag_t'(b1);
		r.b2 = ar_tag_t'(b2);
		r.cdb_v[0] = (cdb_v != 0);
		r.cdb_ar[0] = ar_tag_t'(cdb_ar);
		r.cdb_pr[0] = pr_tag_t'(cdb_pr);
		r.ret = issue_count_t'(ret);
		r.exp_grant = 2'(grant);
		rows.push_back(r);
	endtask

	task automatic build_directed_rows();
		int k;
		// Every register reads its identity mapping
		for (k = 0; k < `AR_COUNT; k += 4)
			add_row(0, 0, 0, 0, 0, k, k + 1, k + 2, k + 3, 0, 0, 0, 0, 0);
		// Slot b reads slot a, then both slots write r5
		add_row(2, 1, 1, 1, 2, 1, 2, 1, 3, 0, 0, 0, 0, 2);
		add_row(2, 1, 5, 1, 5, 5, 6, 5, 1, 0, 0, 0, 0, 2);
		// Wake r1 with its current tag, then try r5 with a stale one
		add_row(0, 0, 0, 0, 0, 5, 1, 2, 3, 1, 1, int'(CURRENT_TAG), 0, 0);
		add_row(0, 0, 0, 0, 0, 1, 5, 2, 3, 1, 5, 34, 0, 0);
		add_row(0, 0, 0, 0, 0, 5, 1, 2, 3, 0, 0, 0, 0, 0);
		// Drain the free list
		for (k = 0; k < 14; k++)
			add_row(2, 1, k + 6, 1, 31 - k, k, 5, 1, 2, 0, 0, 0, 0, 2);
		// Empty list, retire two, reuse them a cycle later
		add_row(1, 1, 3, 0, 0, 3, 5, 1, 2, 0, 0, 0, 0, 0);
		add_row(1, 1, 3, 0, 0, 3, 5, 1, 2, 0, 0, 0, 2, 0);
		add_row(2, 1, 7, 1, 8, 7, 8, 7, 8, 0, 0, 0, 0, 2);
	endtask

	task automatic add_random_rows(input int count);
		row_t r;
		int n;
		int lane;
		for (n = 0; n < count; n++)
		begin
			r.num = issue_count_t'(rand_bits(2) % 3);
			r.va = (rand_bits(1) == 1);
			r.da = ar_tag_t'(rand_bits(5));
			r.vb = (rand_bits(1) == 1);
			r.db = ar_tag_t'(rand_bits(5));
			r.a1 = ar_tag_t'(rand_bits(5));
			r.a2 = ar_tag_t'(rand_bits(5));
			r.b1 = ar_tag_t'(rand_bits(5));
			r.b2 = ar_tag_t'(rand_bits(5));
			r.cdb_v = 4'(rand_bits(4));
			for (lane = 0; lane < `CDB_WIDTH; lane++)
			begin
				r.cdb_ar[lane] = ar_tag_t'(rand_bits(5));
				r.cdb_pr[lane] = (rand_bits(1) == 1) ? CURRENT_TAG : pr_tag_t'(rand_bits(6));
			end
			r.ret = issue_count_t'(rand_bits(2) % 3);
			r.exp_grant = ANY_GRANT;
			rows.push_back(r);
		end
	endtask

	task automatic apply_row(input row_t r, input int idx);
		int needed;
		int ret_n;
		int lane;
		int errors_before;
		issue_count_t grant;
		logic wa;
		logic wb;
		pr_tag_t new_a;
		pr_tag_t new_b;
		pr_tag_t exp_told_a;
		pr_tag_t exp_told_b;
		pr_tag_t retired [2];
		logic [`AR_COUNT-1:0] ready_next;
		@(negedge clock);
		retired[0] = '0;
		retired[1] = '0;
		// Retirement hands back the oldest outstanding old tags
		ret_n = (int'(r.ret) > told_q.size()) ? told_q.size() : int'(r.ret);
		for (lane = 0; lane < ret_n; lane++)
			retired[lane] = told_q.pop_front();
		dispatch_num = r.num;
		dest_a_valid = r.va;
		dest_a = r.da;
		dest_b_valid = r.vb;
		dest_b = r.db;
		src_a1 = r.a1;
		src_a2 = r.a2;
		src_b1 = r.b1;
		src_b2 = r.b2;
		cdb_broadcast = r.cdb_v;
		cdb_ar_tag0 = r.cdb_ar[0];
		cdb_ar_tag1 = r.cdb_ar[1];
		cdb_ar_tag2 = r.cdb_ar[2];
		cdb_ar_tag3 = r.cdb_ar[3];
		cdb_pr_tag0 = lane_tag(r, 0);
		cdb_pr_tag1 = lane_tag(r, 1);
		cdb_pr_tag2 = lane_tag(r, 2);
		cdb_pr_tag3 = lane_tag(r, 3);
		retire_num = issue_count_t'(ret_n);
		retire_told0 = retired[0];
		retire_told1 = retired[1];

		needed = 0;
		if (r.num != 2'd0 && r.va)
			needed++;
		if (r.num == 2'd2 && r.vb)
			needed++;
		grant = (needed <= free_q.size()) ? r.num : 2'd0;
		wa = (grant != 2'd0) && r.va;
		wb = (grant == 2'd2) && r.vb;
		new_a = wa ? free_q[0] : '0;
		new_b = '0;
		if (wb)
			new_b = r.va ? free_q[1] : free_q[0];
		exp_told_a = model_map[r.da];
		exp_told_b = (wa && r.db == r.da) ? new_a : model_map[r.db];

		#2;
		errors_before = errors;
		check_bit("rename_ready", rename_ready, 1'b1);
		check_tag("dispatch_grant", pr_tag_t'(dispatch_grant), pr_tag_t'(grant));
		if (r.exp_grant != ANY_GRANT)
			check_tag("table grant", pr_tag_t'(dispatch_grant), pr_tag_t'(r.exp_grant));
		if (wa)
			check_tag("pr_dest_a", pr_dest_a, new_a);
		if (wb)
			check_tag("pr_dest_b", pr_dest_b, new_b);
		check_tag("told_a", told_a, exp_told_a);
		check_tag("told_b", told_b, exp_told_b);
		check_source("pr_a1", pr_a1, pr_a1_ready, r.a1, 1'b0, new_a);
		check_source("pr_a2", pr_a2, pr_a2_ready, r.a2, 1'b0, new_a);
		check_source("pr_b1", pr_b1, pr_b1_ready, r.b1, wa && (r.b1 == r.da), new_a);
		check_source("pr_b2", pr_b2, pr_b2_ready, r.b2, wa && (r.b2 == r.da), new_a);

		// Wakeup against the old map, then new mappings clear ready
		ready_next = model_ready;
		for (lane = 0; lane < `CDB_WIDTH; lane++)
		begin
			if (r.cdb_v[lane] && model_map[r.cdb_ar[lane]] == lane_tag(r, lane))
				ready_next[r.cdb_ar[lane]] = 1'b1;
		end
		if (wa)
		begin
			ready_next[r.da] = 1'b0;
			told_q.push_back(exp_told_a);
			model_map[r.da] = new_a;
		end
		if (wb)
		begin
			ready_next[r.db] = 1'b0;
			told_q.push_back(exp_told_b);
			model_map[r.db] = new_b;
		end
		model_ready = ready_next;
		if (grant != 2'd0)
		begin
			for (lane = 0; lane < needed; lane++)
				void'(free_q.pop_front());
		end
		for (lane = 0; lane < ret_n; lane++)
			free_q.push_back(retired[lane]);

		if (errors == errors_before)
			$display("row %0d: ok", idx);
		else
		begin
			$display("row %0d: mismatch", idx);
			rows_bad++;
		end
	endtask

	initial
	begin
		int waited;
		int i;
		clock = 1'b0;
		reset = 1'b1;
		dispatch_num = '0;
		dest_a_valid = 1'b0;
		dest_b_valid = 1'b0;
		dest_a = '0;
		dest_b = '0;
		src_a1 = '0;
		src_a2 = '0;
		src_b1 = '0;
		src_b2 = '0;
		cdb_broadcast = '0;
		cdb_pr_tag0 = '0;
		cdb_pr_tag1 = '0;
		cdb_pr_tag2 = '0;
		cdb_pr_tag3 = '0;
		cdb_ar_tag0 = '0;
		cdb_ar_tag1 = '0;
		cdb_ar_tag2 = '0;
		cdb_ar_tag3 = '0;
		retire_num = '0;
		retire_told0 = '0;
		retire_told1 = '0;
		errors = 0;
		rows_bad = 0;
		lfsr = 16'd23490;
		for (i = 0; i < `AR_COUNT; i++)
			model_map[i] = pr_tag_t'(i);
		model_ready = '1;
		// Fill order after reset
		for (i = `AR_COUNT; i < `PR_COUNT; i++)
			free_q.push_back(pr_tag_t'(i));
		build_directed_rows();
		add_random_rows(RANDOM_ROWS);

		repeat (4) @(negedge clock);
		reset = 1'b0;

		waited = 0;
		while (!rename_ready && waited < READY_TIMEOUT)
		begin
			@(negedge clock);
			waited++;
		end
		if (!rename_ready)
		begin
			$display("Timed out waiting for rename_ready after reset");
			$display("TEST FAILED");
		end
		else
		begin
			for (i = 0; i < rows.size(); i++)
				apply_row(rows[i], i);

			$display("rows run: %0d, rows with mismatches: %0d, failed checks: %0d",
				rows.size(), rows_bad, errors);
			if (errors == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/fill_counter.sv
rtl/rename_ctrl.sv
rtl/rename_top.sv
sim/rename_tb.sv
